//--- hw/issue_pkg.sv
// shared widths, vector types and unit/operation encodings
// for the integer issue and operand-read stage

package issue_pkg;

  // --------------------
  // widths
  // --------------------

  // datapath width
  localparam int unsigned XLEN          = 32;
  // register index width
  localparam int unsigned REG_ADDR_SIZE = 5;
  // architectural integer registers, x0 included
  localparam int unsigned NR_REGS       = 32;
  // scoreboard transaction id width
  localparam int unsigned TRANS_ID_BITS = 3;

  // --------------------
  // vector types
  // --------------------

  // operand, register or immediate value
  typedef logic [XLEN-1:0]          xlen_t;
  // register index
  typedef logic [REG_ADDR_SIZE-1:0] reg_addr_t;
  // scoreboard slot tag
  typedef logic [TRANS_ID_BITS-1:0] trans_id_t;
  // instruction address
  typedef logic [XLEN-1:0]          pc_t;

  // --------------------
  // encodings
  // --------------------

  // target functional unit, NONE also marks an empty clobber entry
  typedef enum logic [2:0] {
    NONE,
    LOAD,
    STORE,
    ALU,
    CTRL_FLOW,
    MULT,
    CSR
  } fu_t;

  // operation handed to the unit
  typedef enum logic [3:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLL,
    MUL,
    LW,
    SW,
    BEQ,
    JAL,
    CSRRW,
    SFENCE_VMA
  } fu_op_t;

endpackage

//--- hw/gpr_regfile.sv
// integer register file, two combinational read ports and one write port
// x0 is hard-wired to zero

`timescale 1ns/1ps

module gpr_regfile
  import issue_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  // read ports
  input  reg_addr_t raddr_a_i,
  input  reg_addr_t raddr_b_i,
  output xlen_t     rdata_a_o,
  output xlen_t     rdata_b_o,
  // commit write port
  input  reg_addr_t waddr_i,
  input  xlen_t     wdata_i,
  input  logic      we_i
);

  // entry 0 is never written and stays zero
  xlen_t regs_q [NR_REGS];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned i = 0; i < NR_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      // write lands on the edge, readers see it next cycle
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // --------------------
  // read ports
  // --------------------
  // no bypass from the write port
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

//--- hw/issue_hazard.sv
// operand availability, forwarding select, unit busy and issue acknowledge
// purely combinational

`timescale 1ns/1ps

module issue_hazard
  import issue_pkg::*;
(
  // instruction under issue
  input  logic                  issue_valid_i,
  input  fu_t                   issue_fu_i,
  input  fu_op_t                issue_op_i,
  input  reg_addr_t             issue_rs1_i,
  input  reg_addr_t             issue_rs2_i,
  input  reg_addr_t             issue_rd_i,
  input  logic                  issue_use_zimm_i,
  input  logic                  issue_ex_valid_i,
  // scoreboard view
  input  fu_t [NR_REGS-1:0]     rd_clobber_i,
  input  logic                  rs1_valid_i,
  input  logic                  rs2_valid_i,
  // commit port
  input  reg_addr_t             waddr_i,
  input  logic                  we_i,
  // unit readiness and external stall
  input  logic                  flu_ready_i,
  input  logic                  lsu_ready_i,
  input  logic                  stall_i,
  // multiply strobe of the previous issue
  input  logic                  mult_valid_i,
  // results
  output logic                  fwd_rs1_o,
  output logic                  fwd_rs2_o,
  output logic                  stall_o,
  output logic                  issue_ack_o,
  output logic                  dispatch_o
);

  logic fu_busy;
  logic stall;
  logic rs1_clobbered;
  logic rs2_clobbered;
  logic rs1_avail;
  logic rs2_avail;
  logic rd_free;

  // --------------------
  // unit busy
  // --------------------
  always_comb begin
    unique case (issue_fu_i)
      NONE:                     fu_busy = 1'b0;
      // fixed latency units share one ready
      ALU, CTRL_FLOW, CSR, MULT: fu_busy = ~flu_ready_i;
      LOAD, STORE:              fu_busy = ~lsu_ready_i;
      default:                  fu_busy = 1'b0;
    endcase
  end

  // --------------------
  // operand availability
  // --------------------
  // zimm carries an immediate in rs1, nothing to wait on
  assign rs1_clobbered = !issue_use_zimm_i && (rd_clobber_i[issue_rs1_i] != NONE);
  assign rs2_clobbered = rd_clobber_i[issue_rs2_i] != NONE;

  // csr results only come back through the register file,
  // sfence.vma is the one exception
  assign rs1_avail = rs1_valid_i &&
                     ((rd_clobber_i[issue_rs1_i] != CSR) || (issue_op_i == SFENCE_VMA));
  assign rs2_avail = rs2_valid_i &&
                     ((rd_clobber_i[issue_rs2_i] != CSR) || (issue_op_i == SFENCE_VMA));

  always_comb begin
    stall     = stall_i;
    fwd_rs1_o = 1'b0;
    fwd_rs2_o = 1'b0;
    if (rs1_clobbered) begin
      if (rs1_avail) fwd_rs1_o = 1'b1;
      else           stall     = 1'b1;
    end
    if (rs2_clobbered) begin
      if (rs2_avail) fwd_rs2_o = 1'b1;
      else           stall     = 1'b1;
    end
  end

  assign stall_o = stall;

  // --------------------
  // issue acknowledge
  // --------------------
  // waw check, or rd is retired by the commit port this very cycle
  assign rd_free = (rd_clobber_i[issue_rd_i] == NONE) || (we_i && (waddr_i == issue_rd_i));

  always_comb begin
    issue_ack_o = 1'b0;
    if (issue_valid_i) begin
      if (!stall && !fu_busy && rd_free) issue_ack_o = 1'b1;
      // exceptions pass through regardless of stall
      if (issue_ex_valid_i) issue_ack_o = 1'b1;
      // no unit needed, always goes
      if (issue_fu_i == NONE) issue_ack_o = 1'b1;
    end
    // keep the fixed latency result bus free behind a multiply
    if (mult_valid_i && (issue_fu_i inside {ALU, CTRL_FLOW, CSR})) issue_ack_o = 1'b0;
  end

  // taken and not an exception
  assign dispatch_o = issue_valid_i && issue_ack_o && !issue_ex_valid_i;

endmodule

//--- hw/operand_select.sv
// operand multiplexing and the pipeline registers towards execute

`timescale 1ns/1ps

module operand_select
  import issue_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  // instruction fields
  input  pc_t       issue_pc_i,
  input  fu_t       issue_fu_i,
  input  fu_op_t    issue_op_i,
  input  reg_addr_t issue_rs1_i,
  input  xlen_t     issue_imm_i,
  input  logic      issue_use_imm_i,
  input  logic      issue_use_pc_i,
  input  logic      issue_use_zimm_i,
  input  trans_id_t issue_trans_id_i,
  input  logic      issue_is_compressed_i,
  // register file and scoreboard values
  input  xlen_t     rdata_a_i,
  input  xlen_t     rdata_b_i,
  input  xlen_t     rs1_i,
  input  xlen_t     rs2_i,
  input  logic      fwd_rs1_i,
  input  logic      fwd_rs2_i,
  // unregistered operands
  output xlen_t     rs1_forwarding_o,
  output xlen_t     rs2_forwarding_o,
  // towards execute
  output xlen_t     operand_a_o,
  output xlen_t     operand_b_o,
  output xlen_t     imm_o,
  output fu_t       fu_o,
  output fu_op_t    op_o,
  output trans_id_t trans_id_o,
  output pc_t       pc_o,
  output logic      is_compressed_o
);

  xlen_t operand_a_n;
  xlen_t operand_b_n;

  // --------------------
  // operand a
  // --------------------
  always_comb begin
    if (issue_use_zimm_i) begin
      // zero extended rs1 index
      operand_a_n = {{(XLEN-REG_ADDR_SIZE){1'b0}}, issue_rs1_i};
    end else if (issue_use_pc_i) begin
      operand_a_n = issue_pc_i;
    end else if (fwd_rs1_i) begin
      operand_a_n = rs1_i;
    end else begin
      operand_a_n = rdata_a_i;
    end
  end

  // --------------------
  // operand b
  // --------------------
  // stores and branches keep rs2, the immediate travels on imm
  always_comb begin
    if (issue_use_imm_i && (issue_fu_i != STORE) && (issue_fu_i != CTRL_FLOW)) begin
      operand_b_n = issue_imm_i;
    end else if (fwd_rs2_i) begin
      operand_b_n = rs2_i;
    end else begin
      operand_b_n = rdata_b_i;
    end
  end

  assign rs1_forwarding_o = operand_a_n;
  assign rs2_forwarding_o = operand_b_n;

  // id/ex registers, loaded every cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      operand_a_o     <= '0;
      operand_b_o     <= '0;
      imm_o           <= '0;
      fu_o            <= NONE;
      op_o            <= ADD;
      trans_id_o      <= '0;
      pc_o            <= '0;
      is_compressed_o <= 1'b0;
    end else begin
      operand_a_o     <= operand_a_n;
      operand_b_o     <= operand_b_n;
      imm_o           <= issue_imm_i;
      fu_o            <= issue_fu_i;
      op_o            <= issue_op_i;
      trans_id_o      <= issue_trans_id_i;
      pc_o            <= issue_pc_i;
      is_compressed_o <= issue_is_compressed_i;
    end
  end

endmodule

//--- hw/fu_dispatch.sv
// per-unit valid strobes, one cycle after dispatch, cancelled by flush

`timescale 1ns/1ps

module fu_dispatch
  import issue_pkg::*;
(
  input  logic clk_i,
  input  logic rst_ni,
  input  logic flush_i,
  input  logic dispatch_i,
  input  fu_t  issue_fu_i,
  output logic alu_valid_o,
  output logic branch_valid_o,
  output logic lsu_valid_o,
  output logic mult_valid_o,
  output logic csr_valid_o
);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      alu_valid_o    <= 1'b0;
      branch_valid_o <= 1'b0;
      lsu_valid_o    <= 1'b0;
      mult_valid_o   <= 1'b0;
      csr_valid_o    <= 1'b0;
    end else begin
      // strobes last a single cycle
      alu_valid_o    <= 1'b0;
      branch_valid_o <= 1'b0;
      lsu_valid_o    <= 1'b0;
      mult_valid_o   <= 1'b0;
      csr_valid_o    <= 1'b0;
      // a flush in the taken cycle drops the strobe
      if (dispatch_i && !flush_i) begin
        case (issue_fu_i)
          ALU:         alu_valid_o    <= 1'b1;
          CTRL_FLOW:   branch_valid_o <= 1'b1;
          LOAD, STORE: lsu_valid_o    <= 1'b1;
          MULT:        mult_valid_o   <= 1'b1;
          CSR:         csr_valid_o    <= 1'b1;
          default: ;
        endcase
      end
    end
  end

endmodule

//--- hw/issue_read_operands.sv
// issue and operand-read stage, single issue integer only
// register file, hazard control, operand datapath and unit strobes

`timescale 1ns/1ps

module issue_read_operands
  import issue_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              flush_i,
  input  logic              stall_i,
  // instruction from the decoder
  input  logic              issue_valid_i,
  input  pc_t               issue_pc_i,
  input  fu_t               issue_fu_i,
  input  fu_op_t            issue_op_i,
  input  reg_addr_t         issue_rs1_i,
  input  reg_addr_t         issue_rs2_i,
  input  reg_addr_t         issue_rd_i,
  input  xlen_t             issue_imm_i,
  input  logic              issue_use_imm_i,
  input  logic              issue_use_pc_i,
  input  logic              issue_use_zimm_i,
  input  logic              issue_ex_valid_i,
  input  trans_id_t         issue_trans_id_i,
  input  logic              issue_is_compressed_i,
  output logic              issue_ack_o,
  output logic              stall_issue_o,
  // scoreboard lookup
  output reg_addr_t         rs1_o,
  input  xlen_t             rs1_i,
  input  logic              rs1_valid_i,
  output reg_addr_t         rs2_o,
  input  xlen_t             rs2_i,
  input  logic              rs2_valid_i,
  input  fu_t [NR_REGS-1:0] rd_clobber_i,
  // towards execute
  output fu_t               fu_o,
  output fu_op_t            op_o,
  output xlen_t             operand_a_o,
  output xlen_t             operand_b_o,
  output xlen_t             imm_o,
  output trans_id_t         trans_id_o,
  output xlen_t             rs1_forwarding_o,
  output xlen_t             rs2_forwarding_o,
  output pc_t               pc_o,
  output logic              is_compressed_o,
  // unit handshakes
  input  logic              flu_ready_i,
  input  logic              lsu_ready_i,
  output logic              alu_valid_o,
  output logic              branch_valid_o,
  output logic              lsu_valid_o,
  output logic              mult_valid_o,
  output logic              csr_valid_o,
  // commit port
  input  reg_addr_t         waddr_i,
  input  xlen_t             wdata_i,
  input  logic              we_i
);

  xlen_t rdata_a;
  xlen_t rdata_b;
  logic  fwd_rs1;
  logic  fwd_rs2;
  logic  dispatch;

  // scoreboard is polled with the raw source indices
  assign rs1_o = issue_rs1_i;
  assign rs2_o = issue_rs2_i;

  // --------------------
  // register file
  // --------------------
  gpr_regfile i_gpr_regfile (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (issue_rs1_i),
    .raddr_b_i (issue_rs2_i),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .waddr_i   (waddr_i),
    .wdata_i   (wdata_i),
    .we_i      (we_i)
  );

  // --------------------
  // hazards and ack
  // --------------------
  issue_hazard i_issue_hazard (
    .issue_valid_i    (issue_valid_i),
    .issue_fu_i       (issue_fu_i),
    .issue_op_i       (issue_op_i),
    .issue_rs1_i      (issue_rs1_i),
    .issue_rs2_i      (issue_rs2_i),
    .issue_rd_i       (issue_rd_i),
    .issue_use_zimm_i (issue_use_zimm_i),
    .issue_ex_valid_i (issue_ex_valid_i),
    .rd_clobber_i     (rd_clobber_i),
    .rs1_valid_i      (rs1_valid_i),
    .rs2_valid_i      (rs2_valid_i),
    .waddr_i          (waddr_i),
    .we_i             (we_i),
    .flu_ready_i      (flu_ready_i),
    .lsu_ready_i      (lsu_ready_i),
    .stall_i          (stall_i),
    // multiply strobe loops back for the fixed latency bus rule
    .mult_valid_i     (mult_valid_o),
    .fwd_rs1_o        (fwd_rs1),
    .fwd_rs2_o        (fwd_rs2),
    .stall_o          (stall_issue_o),
    .issue_ack_o      (issue_ack_o),
    .dispatch_o       (dispatch)
  );

  // --------------------
  // operand datapath
  // --------------------
  operand_select i_operand_select (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .issue_pc_i            (issue_pc_i),
    .issue_fu_i            (issue_fu_i),
    .issue_op_i            (issue_op_i),
    .issue_rs1_i           (issue_rs1_i),
    .issue_imm_i           (issue_imm_i),
    .issue_use_imm_i       (issue_use_imm_i),
    .issue_use_pc_i        (issue_use_pc_i),
    .issue_use_zimm_i      (issue_use_zimm_i),
    .issue_trans_id_i      (issue_trans_id_i),
    .issue_is_compressed_i (issue_is_compressed_i),
    .rdata_a_i             (rdata_a),
    .rdata_b_i             (rdata_b),
    .rs1_i                 (rs1_i),
    .rs2_i                 (rs2_i),
    .fwd_rs1_i             (fwd_rs1),
    .fwd_rs2_i             (fwd_rs2),
    .rs1_forwarding_o      (rs1_forwarding_o),
    .rs2_forwarding_o      (rs2_forwarding_o),
    .operand_a_o           (operand_a_o),
    .operand_b_o           (operand_b_o),
    .imm_o                 (imm_o),
    .fu_o                  (fu_o),
    .op_o                  (op_o),
    .trans_id_o            (trans_id_o),
    .pc_o                  (pc_o),
    .is_compressed_o       (is_compressed_o)
  );

  // unit strobes
  fu_dispatch i_fu_dispatch (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .dispatch_i     (dispatch),
    .issue_fu_i     (issue_fu_i),
    .alu_valid_o    (alu_valid_o),
    .branch_valid_o (branch_valid_o),
    .lsu_valid_o    (lsu_valid_o),
    .mult_valid_o   (mult_valid_o),
    .csr_valid_o    (csr_valid_o)
  );

endmodule

//--- testbench/tb_issue_read_operands.sv
// directed testbench for the issue and operand-read stage
// clock, reset, lfsr data, compare tasks, bounded waits and test tasks

`timescale 1ns/1ps

module tb_issue_read_operands
  import issue_pkg::*;
();

  logic              clk_i = 1'b0;
  logic              rst_ni;
  logic              flush_i;
  logic              stall_i;
  logic              issue_valid_i;
  pc_t               issue_pc_i;
  fu_t               issue_fu_i;
  fu_op_t            issue_op_i;
  reg_addr_t         issue_rs1_i;
  reg_addr_t         issue_rs2_i;
  reg_addr_t         issue_rd_i;
  xlen_t             issue_imm_i;
  logic              issue_use_imm_i;
  logic              issue_use_pc_i;
  logic              issue_use_zimm_i;
  logic              issue_ex_valid_i;
  trans_id_t         issue_trans_id_i;
  logic              issue_is_compressed_i;
  logic              issue_ack_o;
  logic              stall_issue_o;
  reg_addr_t         rs1_o;
  xlen_t             rs1_i;
  logic              rs1_valid_i;
  reg_addr_t         rs2_o;
  xlen_t             rs2_i;
  logic              rs2_valid_i;
  fu_t [NR_REGS-1:0] rd_clobber_i;
  fu_t               fu_o;
  fu_op_t            op_o;
  xlen_t             operand_a_o;
  xlen_t             operand_b_o;
  xlen_t             imm_o;
  trans_id_t         trans_id_o;
  xlen_t             rs1_forwarding_o;
  xlen_t             rs2_forwarding_o;
  pc_t               pc_o;
  logic              is_compressed_o;
  logic              flu_ready_i;
  logic              lsu_ready_i;
  logic              alu_valid_o;
  logic              branch_valid_o;
  logic              lsu_valid_o;
  logic              mult_valid_o;
  logic              csr_valid_o;
  reg_addr_t         waddr_i;
  xlen_t             wdata_i;
  logic              we_i;

  // reference copy of the register file, x0 never written
  xlen_t       exp_regs [NR_REGS];
  // lfsr state, seeded once
  logic [31:0] lfsr_q = 32'd92;

  issue_read_operands dut (.*);

  // 100 ns period
  always #50 clk_i = ~clk_i;

  // --------------------
  // random data
  // --------------------
  // galois form, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      lfsr_next = (s >> 1) ^ 32'h80200003;
    end else begin
      lfsr_next = s >> 1;
    end
  endfunction

  // one lfsr step per bit taken
  task automatic rand_bits(input int unsigned n, output xlen_t v);
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[XLEN-2:0], lfsr_q[0]};
    end
  endtask

  // --------------------
  // compare tasks
  // --------------------
  task automatic check_xlen(input string name, input xlen_t act, input xlen_t exp);
    if (act !== exp) begin
      $display("** Error at %0t ns: %s is 0x%08h, expected 0x%08h", $time, name, act, exp);
      $display("Test failed");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic check_fu(input string name, input fu_t act, input fu_t exp);
    if (act !== exp) begin
      $display("** Error at %0t ns: %s is %s, expected %s", $time, name, act.name(),
               exp.name());
      $display("Test failed");
      $fatal(1, "unit mismatch");
    end
  endtask

  task automatic check_op(input string name, input fu_op_t act, input fu_op_t exp);
    if (act !== exp) begin
      $display("** Error at %0t ns: %s is %s, expected %s", $time, name, act.name(),
               exp.name());
      $display("Test failed");
      $fatal(1, "operation mismatch");
    end
  endtask

  task automatic check_addr(input string name, input reg_addr_t act,
                            input reg_addr_t exp);
    if (act !== exp) begin
      $display("** Error at %0t ns: %s is %0d, expected %0d", $time, name, act, exp);
      $display("Test failed");
      $fatal(1, "register index mismatch");
    end
  endtask

  task automatic check_trans_id(input string name, input trans_id_t act,
                                input trans_id_t exp);
    if (act !== exp) begin
      $display("** Error at %0t ns: %s is %0d, expected %0d", $time, name, act, exp);
      $display("Test failed");
      $fatal(1, "transaction id mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      $display("** Error at %0t ns: %s is %b, expected %b", $time, name, act, exp);
      $display("Test failed");
      $fatal(1, "bit mismatch");
    end
  endtask

  task automatic check_strobes(input logic alu, input logic branch, input logic lsu,
                               input logic mult, input logic csr);
    check_bit("alu_valid_o", alu_valid_o, alu);
    check_bit("branch_valid_o", branch_valid_o, branch);
    check_bit("lsu_valid_o", lsu_valid_o, lsu);
    check_bit("mult_valid_o", mult_valid_o, mult);
    check_bit("csr_valid_o", csr_valid_o, csr);
  endtask

  // --------------------
  // drivers
  // --------------------
  // quiet instruction, empty scoreboard, units ready
  task automatic idle_inputs();
    flush_i               <= 1'b0;
    stall_i               <= 1'b0;
    issue_valid_i         <= 1'b0;
    issue_pc_i            <= '0;
    issue_fu_i            <= NONE;
    issue_op_i            <= ADD;
    issue_rs1_i           <= '0;
    issue_rs2_i           <= '0;
    issue_rd_i            <= '0;
    issue_imm_i           <= '0;
    issue_use_imm_i       <= 1'b0;
    issue_use_pc_i        <= 1'b0;
    issue_use_zimm_i      <= 1'b0;
    issue_ex_valid_i      <= 1'b0;
    issue_trans_id_i      <= '0;
    issue_is_compressed_i <= 1'b0;
    rs1_i                 <= '0;
    rs1_valid_i           <= 1'b0;
    rs2_i                 <= '0;
    rs2_valid_i           <= 1'b0;
    flu_ready_i           <= 1'b1;
    lsu_ready_i           <= 1'b1;
    waddr_i               <= '0;
    wdata_i               <= '0;
    we_i                  <= 1'b0;
    for (int unsigned i = 0; i < NR_REGS; i++) begin
      rd_clobber_i[i] <= NONE;
    end
  endtask

  // present an instruction from the next rising edge, flags cleared
  task automatic set_instr(input fu_t fu, input fu_op_t op, input reg_addr_t rs1,
                           input reg_addr_t rs2, input reg_addr_t rd);
    @(posedge clk_i);
    issue_valid_i    <= 1'b1;
    issue_fu_i       <= fu;
    issue_op_i       <= op;
    issue_rs1_i      <= rs1;
    issue_rs2_i      <= rs2;
    issue_rd_i       <= rd;
    issue_use_imm_i  <= 1'b0;
    issue_use_pc_i   <= 1'b0;
    issue_use_zimm_i <= 1'b0;
    issue_ex_valid_i <= 1'b0;
  endtask

  // commit port write, visible from the cycle after the edge
  task automatic write_reg(input reg_addr_t addr, input xlen_t data);
    @(posedge clk_i);
    we_i    <= 1'b1;
    waddr_i <= addr;
    wdata_i <= data;
    @(posedge clk_i);
    we_i <= 1'b0;
    if (addr != '0) begin
      exp_regs[addr] = data;
    end
  endtask

  // sampled at the falling edge, away from the driving edge
  task automatic wait_ack(input string what);
    bit seen;
    seen = 1'b0;
    for (int i = 0; i < 32 && !seen; i++) begin
      @(negedge clk_i);
      seen = issue_ack_o;
    end
    if (!seen) begin
      $display("timeout: %s was never acknowledged", what);
      $display("Test failed");
      $fatal(1, "issue ack timeout");
    end
  endtask

  // handshake completes, then land in the cycle after the take
  task automatic take_instr(input string what);
    wait_ack(what);
    @(posedge clk_i);
    issue_valid_i <= 1'b0;
    @(negedge clk_i);
  endtask

  // --------------------
  // directed tests
  // --------------------
  task automatic test_reset();
    @(negedge clk_i);
    check_strobes(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    check_fu("fu_o", fu_o, NONE);
    check_op("op_o", op_o, ADD);
    check_trans_id("trans_id_o", trans_id_o, '0);
    check_bit("issue_ack_o", issue_ack_o, 1'b0);
    check_xlen("operand_a_o", operand_a_o, '0);
  endtask

  task automatic test_regfile_operands();
    reg_addr_t addrs [6];
    xlen_t     r;
    xlen_t     data;
    xlen_t     imm;
    trans_id_t tid;
    // first write aims at x0
    for (int i = 0; i < 6; i++) begin
      rand_bits(REG_ADDR_SIZE, r);
      addrs[i] = (i == 0) ? '0 : r[REG_ADDR_SIZE-1:0];
      rand_bits(XLEN, data);
      write_reg(addrs[i], data);
    end
    for (int i = 0; i < 6; i++) begin
      set_instr(ALU, ADD, addrs[i], addrs[(i + 1) % 6], 5'd1);
      rand_bits(TRANS_ID_BITS, r);
      tid = r[TRANS_ID_BITS-1:0];
      issue_trans_id_i <= tid;
      take_instr("alu register read");
      check_strobes(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
      check_xlen("operand_a_o", operand_a_o, exp_regs[addrs[i]]);
      check_xlen("operand_b_o", operand_b_o, exp_regs[addrs[(i + 1) % 6]]);
      check_trans_id("trans_id_o", trans_id_o, tid);
      @(negedge clk_i);
      check_bit("alu_valid_o", alu_valid_o, 1'b0);
    end
    // immediate replaces rs2 for the alu
    rand_bits(XLEN, imm);
    set_instr(ALU, ADD, addrs[1], addrs[2], 5'd1);
    issue_use_imm_i <= 1'b1;
    issue_imm_i     <= imm;
    take_instr("alu immediate");
    check_xlen("operand_b_o", operand_b_o, imm);
    check_xlen("imm_o", imm_o, imm);
    // store keeps rs2 even with an immediate
    set_instr(STORE, SW, addrs[1], addrs[2], 5'd1);
    issue_use_imm_i <= 1'b1;
    take_instr("store immediate");
    check_strobes(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
    check_op("op_o", op_o, SW);
    check_xlen("operand_b_o", operand_b_o, exp_regs[addrs[2]]);
    check_xlen("imm_o", imm_o, imm);
    // pc on operand a, branch keeps rs2
    rand_bits(XLEN, data);
    set_instr(CTRL_FLOW, JAL, addrs[3], addrs[4], 5'd1);
    issue_use_pc_i        <= 1'b1;
    issue_use_imm_i       <= 1'b1;
    issue_pc_i            <= data;
    issue_is_compressed_i <= 1'b1;
    take_instr("jump with pc");
    check_strobes(1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
    check_op("op_o", op_o, JAL);
    check_xlen("operand_a_o", operand_a_o, data);
    check_xlen("operand_b_o", operand_b_o, exp_regs[addrs[4]]);
    check_xlen("pc_o", pc_o, data);
    check_bit("is_compressed_o", is_compressed_o, 1'b1);
    // zimm outranks the pc
    set_instr(CSR, CSRRW, 5'd19, addrs[4], 5'd1);
    issue_use_zimm_i <= 1'b1;
    issue_use_pc_i   <= 1'b1;
    take_instr("csr zimm");
    check_strobes(1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
    check_op("op_o", op_o, CSRRW);
    check_xlen("operand_a_o", operand_a_o, 32'd19);
  endtask

  task automatic test_forwarding();
    xlen_t v1;
    xlen_t v2;
    rand_bits(XLEN, v1);
    rand_bits(XLEN, v2);
    set_instr(ALU, ADD, 5'd5, 5'd6, 5'd1);
    rd_clobber_i[5] <= ALU;
    rd_clobber_i[6] <= MULT;
    rs1_valid_i     <= 1'b1;
    rs1_i           <= v1;
    rs2_valid_i     <= 1'b1;
    rs2_i           <= v2;
    take_instr("forwarded alu");
    check_strobes(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    // scoreboard lookup follows the source indices
    check_addr("rs1_o", rs1_o, 5'd5);
    check_addr("rs2_o", rs2_o, 5'd6);
    check_xlen("rs1_forwarding_o", rs1_forwarding_o, v1);
    check_xlen("rs2_forwarding_o", rs2_forwarding_o, v2);
    check_xlen("operand_a_o", operand_a_o, v1);
    check_xlen("operand_b_o", operand_b_o, v2);
    // scoreboard value not yet there
    @(posedge clk_i);
    issue_valid_i <= 1'b1;
    rs1_valid_i   <= 1'b0;
    @(negedge clk_i);
    check_bit("issue_ack_o", issue_ack_o, 1'b0);
    check_bit("stall_issue_o", stall_issue_o, 1'b1);
    // csr result is never forwarded
    @(posedge clk_i);
    rs1_valid_i     <= 1'b1;
    rd_clobber_i[5] <= CSR;
    issue_fu_i      <= CSR;
    @(negedge clk_i);
    check_bit("issue_ack_o", issue_ack_o, 1'b0);
    check_bit("stall_issue_o", stall_issue_o, 1'b1);
    @(posedge clk_i);
    issue_op_i <= SFENCE_VMA;
    take_instr("sfence.vma");
    check_bit("stall_issue_o", stall_issue_o, 1'b0);
    check_xlen("operand_a_o", operand_a_o, v1);
    check_strobes(1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
  endtask

  task automatic test_waw_passthrough();
    xlen_t v;
    rand_bits(XLEN, v);
    set_instr(ALU, ADD, 5'd2, 5'd3, 5'd7);
    rd_clobber_i[7] <= LOAD;
    @(negedge clk_i);
    check_bit("issue_ack_o", issue_ack_o, 1'b0);
    check_bit("stall_issue_o", stall_issue_o, 1'b0);
    // commit retires rd in this very cycle
    @(posedge clk_i);
    we_i    <= 1'b1;
    waddr_i <= 5'd7;
    wdata_i <= v;
    wait_ack("waw with commit");
    @(posedge clk_i);
    issue_valid_i <= 1'b0;
    we_i          <= 1'b0;
    @(negedge clk_i);
    exp_regs[7] = v;
    check_strobes(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    // exception goes through a stall, no strobe
    set_instr(LOAD, LW, 5'd9, 5'd10, 5'd11);
    rd_clobber_i[9]  <= ALU;
    issue_ex_valid_i <= 1'b1;
    take_instr("exception pass-through");
    check_bit("stall_issue_o", stall_issue_o, 1'b1);
    check_strobes(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    // no unit, acknowledged under external stall and waw
    set_instr(NONE, ADD, 5'd9, 5'd10, 5'd11);
    stall_i          <= 1'b1;
    rd_clobber_i[11] <= ALU;
    take_instr("unit none");
    check_strobes(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic test_busy_mult();
    set_instr(ALU, ADD, 5'd1, 5'd2, 5'd3);
    flu_ready_i <= 1'b0;
    @(negedge clk_i);
    check_bit("issue_ack_o", issue_ack_o, 1'b0);
    @(posedge clk_i);
    flu_ready_i <= 1'b1;
    take_instr("alu after flu ready");
    check_strobes(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    set_instr(LOAD, LW, 5'd1, 5'd2, 5'd3);
    lsu_ready_i <= 1'b0;
    @(negedge clk_i);
    check_bit("issue_ack_o", issue_ack_o, 1'b0);
    @(posedge clk_i);
    issue_fu_i <= STORE;
    issue_op_i <= SW;
    @(negedge clk_i);
    check_bit("issue_ack_o", issue_ack_o, 1'b0);
    @(posedge clk_i);
    lsu_ready_i <= 1'b1;
    take_instr("store after lsu ready");
    check_strobes(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
    // alu held back while the multiply strobe is out
    set_instr(MULT, MUL, 5'd1, 5'd2, 5'd3);
    wait_ack("first mult");
    set_instr(ALU, ADD, 5'd4, 5'd5, 5'd6);
    @(negedge clk_i);
    check_bit("mult_valid_o", mult_valid_o, 1'b1);
    check_bit("issue_ack_o", issue_ack_o, 1'b0);
    take_instr("alu after mult");
    check_strobes(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    // back to back multiplies are fine
    set_instr(MULT, MUL, 5'd1, 5'd2, 5'd3);
    wait_ack("mult");
    set_instr(MULT, MUL, 5'd4, 5'd5, 5'd6);
    @(negedge clk_i);
    check_bit("mult_valid_o", mult_valid_o, 1'b1);
    check_bit("issue_ack_o", issue_ack_o, 1'b1);
    @(posedge clk_i);
    issue_valid_i <= 1'b0;
    @(negedge clk_i);
    check_strobes(1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
  endtask

  task automatic test_flush();
    set_instr(LOAD, LW, 5'd1, 5'd2, 5'd3);
    flush_i <= 1'b1;
    wait_ack("flushed load");
    @(posedge clk_i);
    issue_valid_i <= 1'b0;
    flush_i       <= 1'b0;
    @(negedge clk_i);
    check_strobes(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    check_fu("fu_o", fu_o, LOAD);
  endtask

  // --------------------
  // sequence
  // --------------------
  initial begin
    for (int unsigned i = 0; i < NR_REGS; i++) begin
      exp_regs[i] = '0;
    end
    idle_inputs();
    rst_ni <= 1'b0;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    test_reset();
    test_regfile_operands();
    @(posedge clk_i);
    idle_inputs();
    test_forwarding();
    @(posedge clk_i);
    idle_inputs();
    test_waw_passthrough();
    @(posedge clk_i);
    idle_inputs();
    test_busy_mult();
    @(posedge clk_i);
    idle_inputs();
    test_flush();
    $display("Test completed successfully");
    $finish;
  end

endmodule

//--- flist.f
hw/issue_pkg.sv
hw/gpr_regfile.sv
hw/issue_hazard.sv
hw/operand_select.sv
hw/fu_dispatch.sv
hw/issue_read_operands.sv
testbench/tb_issue_read_operands.sv

//--- Makefile
# build and run the testbench with Verilator, a failing check exits nonzero

.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 -f flist.f --top-module tb_issue_read_operands -o tb_sim
	./obj_dir/tb_sim

clean:
	rm -rf obj_dir
